//--- Makefile
# Verilator build and run of the matrix multiplier testbench

VERILATOR ?= verilator
TOP       ?= mat_mult_tb
FLAGS     ?= --binary --assert -Wno-fatal
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and pass only if the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS FILELIST OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/mat_mult_checks.sv
`timescale 1ns/1ps

module mat_mult_checks
    import mat_dims_pkg::*;
    import mat_data_pkg::*;
(
    input  logic     vector_mult_done,
    input  logic     arst_n,
    input  mat_job_t job,
    input  mat_res_t result,
    input  logic     done,
    input  mat_res_t exp_result,
    output int       error_count,
    output int       done_count
);

    // cycles from the edge that samples start to the edge that raises done
    localparam int total_cycles = mat_l * mat_n * dot_steps + 1;

    // start was high at the previous falling edge, so the rising edge since then sampled it
    logic     start_seen;
    logic     running;
    logic     started_once;
    logic     done_q;
    mat_res_t result_q;
    int       cycles;

    initial begin
        error_count = 0;
        done_count = 0;
        start_seen = 1'b0;
        running = 1'b0;
        started_once = 1'b0;
        done_q = 1'b0;
        result_q = '0;
        cycles = 0;
    end

    // everything is sampled mid-cycle, where DUT outputs and driven inputs are settled
    always @(negedge vector_mult_done) begin
        if (!arst_n) begin
            running = 1'b0;
            started_once = 1'b0;
            assert (done == 1'b0) else begin
                error_count++;
                $display("ERROR done in reset expected 0x0 got 0x%0h at %0t", done, $time);
            end
        end else if (start_seen) begin
            // the start edge has just passed so done must already be low
            started_once = 1'b1;
            running = 1'b1;
            cycles = 0;
            assert (done == 1'b0) else begin
                error_count++;
                $display("ERROR done after start expected 0x0 got 0x%0h at %0t", done, $time);
            end
        end else if (running) begin
            cycles++;
            if (done) begin
                running = 1'b0;
                done_count++;
                assert (cycles == total_cycles) else begin
                    error_count++;
                    $display("ERROR done latency expected 0x%0h got 0x%0h at %0t",
                             total_cycles, cycles, $time);
                end
                for (int w = 0; w < res_words; w++) begin
                    assert (result[w] == exp_result[w]) else begin
                        error_count++;
                        $display("ERROR result[%0d] expected 0x%08h got 0x%08h at %0t",
                                 w, exp_result[w], result[w], $time);
                    end
                end
            end else begin
                assert (cycles < total_cycles) else begin
                    error_count++;
                    running = 1'b0;
                    $display("done did not rise within %0d cycles of start at %0t",
                             total_cycles, $time);
                end
            end
        end else if (done_q) begin
            // no start came, so the finished product has to sit still
            assert (done == 1'b1) else begin
                error_count++;
                $display("done fell without a new start at %0t", $time);
            end
            assert (result == result_q) else begin
                error_count++;
                $display("ERROR result while holding expected 0x%0h got 0x%0h at %0t",
                         result_q, result, $time);
            end
        end else begin
            assert (done == 1'b0) else begin
                error_count++;
                $display("done rose with no job in flight at %0t", $time);
            end
        end

        // nothing has been computed yet, so the product register is still cleared
        if (!started_once) begin
            assert (result == '0) else begin
                error_count++;
                $display("ERROR result before first job expected 0x0 got 0x%0h at %0t",
                         result, $time);
            end
        end

        done_q = done;
        result_q = result;
        start_seen = arst_n && job.start;
    end

endmodule

//--- dv/mat_mult_tb.sv
`timescale 1ns/1ps

module mat_mult_tb
    import mat_dims_pkg::*;
    import mat_data_pkg::*;
();

    localparam int clk_period = 40;
    localparam int drive_delay = 5;
    localparam int job_cycles = mat_l * mat_n * dot_steps + 1;
    // identity, three random, and the aborted and restarted pair
    localparam int num_jobs = 6;
    localparam int expected_dones = 5;
    localparam int margin_cycles = 100;
    localparam int watchdog_ns = ((num_jobs + 2) * job_cycles + margin_cycles) * clk_period;

    logic        vector_mult_done;
    logic        arst_n;
    mat_job_t    job;
    mat_res_t    result;
    logic        done;
    mat_res_t    exp_result;
    int          check_errors;
    int          done_count;
    int          tb_errors;
    int          timeout_count;
    int unsigned seed_value;

    mat_mult_top mat_mult_top_i (
        .vector_mult_done(vector_mult_done),
        .arst_n(arst_n),
        .job(job),
        .result(result),
        .done(done)
    );

    mat_mult_checks mat_mult_checks_i (
        .vector_mult_done(vector_mult_done),
        .arst_n(arst_n),
        .job(job),
        .result(result),
        .done(done),
        .exp_result(exp_result),
        .error_count(check_errors),
        .done_count(done_count)
    );

    initial begin
        vector_mult_done = 1'b0;
        forever #(clk_period / 2) vector_mult_done = ~vector_mult_done;
    end

    // signed products taken to 64 bits, then only the low word is accumulated
    task automatic compute_reference(input mat_a_t a, input mat_bt_t b_t, output mat_res_t r);
        longint prod;
        word_t  acc;
        for (int i = 0; i < mat_l; i++) begin
            for (int j = 0; j < mat_n; j++) begin
                acc = '0;
                for (int k = 0; k < mat_m; k++) begin
                    prod = longint'($signed(a[i * mat_m + k])) *
                           longint'($signed(b_t[j * mat_m + k]));
                    acc = acc + prod[31:0];
                end
                r[i * mat_n + j] = acc;
            end
        end
    endtask

    function automatic mat_a_t random_a();
        mat_a_t v;
        for (int w = 0; w < mat_l * mat_m; w++) begin
            v[w] = $urandom;
        end
        return v;
    endfunction

    function automatic mat_bt_t random_bt();
        mat_bt_t v;
        for (int w = 0; w < mat_n * mat_m; w++) begin
            v[w] = $urandom;
        end
        return v;
    endfunction

    // one-cycle start strobe, then the operand inputs are scrambled to prove they were captured
    task automatic start_job(input mat_a_t a, input mat_bt_t b_t);
        mat_res_t r;
        compute_reference(a, b_t, r);
        @(posedge vector_mult_done);
        #drive_delay;
        job.start = 1'b1;
        job.a = a;
        job.b_t = b_t;
        exp_result = r;
        @(posedge vector_mult_done);
        #drive_delay;
        job.start = 1'b0;
        job.a = random_a();
        job.b_t = random_bt();
    endtask

    task automatic wait_for_done(input int limit);
        int n;
        n = 0;
        while (done !== 1'b1 && n < limit) begin
            @(negedge vector_mult_done);
            n++;
        end
        if (done !== 1'b1) begin
            timeout_count++;
            $display("timeout, done did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        #watchdog_ns;
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        mat_a_t  id_a;
        mat_bt_t id_bt;
        seed_value = $urandom(32'h7d2a7010);
        job = '0;
        exp_result = '0;
        arst_n = 1'b0;
        tb_errors = 0;
        timeout_count = 0;
        repeat (2) @(posedge vector_mult_done);
        #drive_delay;
        arst_n = 1'b1;
        // a few idle cycles so the cleared state is seen before any job
        repeat (3) @(posedge vector_mult_done);

        // column j of B picks word 2j+1 of each row of A
        for (int w = 0; w < mat_l * mat_m; w++) begin
            id_a[w] = word_t'((w / mat_m) * 16 + (w % mat_m) + 1);
        end
        for (int w = 0; w < mat_n * mat_m; w++) begin
            id_bt[w] = ((w % mat_m) == 2 * (w / mat_m) + 1) ? 32'd1 : 32'd0;
        end
        start_job(id_a, id_bt);
        wait_for_done(job_cycles + 10);

        // full-range words, so nearly every product wraps
        for (int n = 0; n < 3; n++) begin
            start_job(random_a(), random_bt());
            wait_for_done(job_cycles + 10);
        end

        // the second start lands 10 cycles after the first one
        start_job(random_a(), random_bt());
        repeat (8) @(posedge vector_mult_done);
        start_job(random_a(), random_bt());
        wait_for_done(job_cycles + 10);

        // no further start, the checker watches the product stay put
        repeat (20) @(negedge vector_mult_done);

        assert (done_count == expected_dones) else begin
            tb_errors++;
            $display("only %0d of %0d jobs reported done", done_count, expected_dones);
        end
        $display("checker errors: %0d, testbench errors: %0d, timeouts: %0d",
                 check_errors, tb_errors, timeout_count);
        if (check_errors == 0 && tb_errors == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src/mat_data_pkg.sv
package mat_data_pkg;

    import mat_dims_pkg::*;

    // one 32-bit two's complement matrix element
    typedef logic [31:0] word_t;

    // one row of A or one row of B_T, word 0 sits in the low bits
    typedef word_t [mat_m-1:0] vec_t;

    // whole operands and result, all row-major with element 0 in the low bits
    typedef word_t [mat_l*mat_m-1:0] mat_a_t;
    typedef word_t [mat_n*mat_m-1:0] mat_bt_t;
    typedef word_t [mat_l*mat_n-1:0] mat_res_t;

    // request from outside, operands are only looked at while start is high
    typedef struct packed {
        logic    start;
        mat_a_t  a;
        mat_bt_t b_t;
    } mat_job_t;

    // one vector pair handed to the dot-product engine
    typedef struct packed {
        logic             go;
        logic             last;
        vec_t             a_vec;
        vec_t             b_vec;
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
    } dot_req_t;

    // finished dot product with its tags carried along
    typedef struct packed {
        logic             valid;
        logic             last;
        word_t            sum;
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
    } dot_res_t;

endpackage

//--- src/mat_dims_pkg.sv
package mat_dims_pkg;

    // rows of A and rows of the product
    localparam int mat_l = 2;

    // inner dimension shared by a row of A and a column of B
    localparam int mat_m = 8;

    // columns of B, which are the rows of B_T, and columns of the product
    localparam int mat_n = 3;

    // number of multiply lanes working side by side in the engine
    localparam int mod_count = 2;

    // the engine needs this many cycles per output element
    // mat_m has to be a multiple of mod_count for the slices to line up
    localparam int dot_steps = mat_m / mod_count;

    // counter widths, never narrower than one bit so a size of one still works
    localparam int row_w = (mat_l > 1) ? $clog2(mat_l) : 1;
    localparam int col_w = (mat_n > 1) ? $clog2(mat_n) : 1;
    localparam int step_w = (dot_steps > 1) ? $clog2(dot_steps) : 1;

    // total number of elements in the product
    localparam int res_words = mat_l * mat_n;

endpackage

//--- src/mat_mult_seq.sv
`timescale 1ns/1ps

module mat_mult_seq
    import mat_dims_pkg::*;
    import mat_data_pkg::*;
(
    input  logic     vector_mult_done,
    input  logic     arst_n,
    input  mat_job_t job,
    input  logic     busy,
    output dot_req_t req,
    output logic     abort,
    output logic     clear
);

    // operands captured on start, the job inputs may change afterwards
    mat_a_t  op_a;
    mat_bt_t op_b;

    // row of A and row of B_T for the element offered next
    logic [row_w-1:0] cnt_a;
    logic [col_w-1:0] cnt_b;

    // high while elements of the current job still have to be issued
    logic pending;

    logic last_elem;
    logic row_end;

    assign row_end = (cnt_b == col_w'(mat_n - 1));
    assign last_elem = row_end && (cnt_a == row_w'(mat_l - 1));

    // a start takes effect on its own edge, in the engine and in the store alike
    assign abort = job.start;
    assign clear = job.start;

    // go is offered whenever the engine is idle or handing back its result,
    // so elements run back to back without a gap cycle
    assign req.go = pending && !busy;
    assign req.last = last_elem;
    assign req.a_vec = op_a[int'(cnt_a) * mat_m +: mat_m];
    assign req.b_vec = op_b[int'(cnt_b) * mat_m +: mat_m];
    assign req.row = cnt_a;
    assign req.col = cnt_b;

    always_ff @(posedge vector_mult_done) begin
        if (job.start) begin
            op_a <= job.a;
            op_b <= job.b_t;
        end
    end

    always_ff @(posedge vector_mult_done or negedge arst_n) begin
        if (!arst_n) begin
            cnt_a <= '0;
            cnt_b <= '0;
            pending <= 1'b0;
        end else if (job.start) begin
            // a start in mid-run simply begins the walk again from element 0
            cnt_a <= '0;
            cnt_b <= '0;
            pending <= 1'b1;
        end else if (req.go) begin
            // the engine takes the pair on this edge, move on in row-major order
            if (last_elem) begin
                pending <= 1'b0;
                cnt_a <= '0;
                cnt_b <= '0;
            end else if (row_end) begin
                cnt_b <= '0;
                cnt_a <= cnt_a + 1'b1;
            end else begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

endmodule

//--- src/mat_mult_top.sv
`timescale 1ns/1ps

module mat_mult_top
    import mat_data_pkg::*;
(
    input  logic     vector_mult_done,
    input  logic     arst_n,
    input  mat_job_t job,
    output mat_res_t result,
    output logic     done
);

    // sequencer to engine
    dot_req_t req;
    logic     abort;

    // engine back to sequencer and on to the store
    logic     busy;
    dot_res_t res;

    // sequencer to store, drops done on every start
    logic clear;

    mat_mult_seq mat_mult_seq_i (
        .vector_mult_done(vector_mult_done),
        .arst_n(arst_n),
        .job(job),
        .busy(busy),
        .req(req),
        .abort(abort),
        .clear(clear)
    );

    vec_dot_seq vec_dot_seq_i (
        .vector_mult_done(vector_mult_done),
        .arst_n(arst_n),
        .req(req),
        .abort(abort),
        .res(res),
        .busy(busy)
    );

    mat_result_store mat_result_store_i (
        .vector_mult_done(vector_mult_done),
        .arst_n(arst_n),
        .res(res),
        .clear(clear),
        .result(result),
        .done(done)
    );

endmodule

//--- src/mat_result_store.sv
`timescale 1ns/1ps

module mat_result_store
    import mat_dims_pkg::*;
    import mat_data_pkg::*;
(
    input  logic     vector_mult_done,
    input  logic     arst_n,
    input  dot_res_t res,
    input  logic     clear,
    output mat_res_t result,
    output logic     done
);

    // row-major slot of the incoming element
    int slot;

    assign slot = int'(res.row) * mat_n + int'(res.col);

    always_ff @(posedge vector_mult_done or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done <= 1'b0;
        end else if (clear) begin
            // old words stay visible until the new job overwrites them
            // a result still draining from an aborted job is dropped here
            done <= 1'b0;
        end else if (res.valid) begin
            result[slot] <= res.sum;
            // the marker rides along with the final element, so no count is kept here
            if (res.last) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- src/vec_dot_seq.sv
`timescale 1ns/1ps

module vec_dot_seq
    import mat_dims_pkg::*;
    import mat_data_pkg::*;
(
    input  logic     vector_mult_done,
    input  logic     arst_n,
    input  dot_req_t req,
    input  logic     abort,
    output dot_res_t res,
    output logic     busy
);

    // latched vector pair and tags of the element in flight
    vec_t             a_q;
    vec_t             b_q;
    logic [row_w-1:0] row_q;
    logic [col_w-1:0] col_q;
    logic             last_q;

    // running sum of the slices already consumed
    word_t acc;

    // control state
    logic              active;
    logic [step_w-1:0] step;
    logic              final_step;

    // sum of the mod_count lane products for the current slice
    word_t lane_sum;

    // products and sums keep only their low 32 bits, so signedness does not matter here
    always_comb begin
        int base;
        base = int'(step) * mod_count;
        lane_sum = '0;
        for (int k = 0; k < mod_count; k++) begin
            lane_sum = lane_sum + word_t'(a_q[base + k] * b_q[base + k]);
        end
    end

    assign final_step = (step == step_w'(dot_steps - 1));

    // the engine can take a new go in the cycle that its result leaves
    assign busy = active && !final_step;

    // the last slice is added on the way out so valid lands on the same cycle as the sum
    assign res.valid = active && final_step;
    assign res.sum = acc + lane_sum;
    assign res.last = last_q;
    assign res.row = row_q;
    assign res.col = col_q;

    always_ff @(posedge vector_mult_done or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            step <= '0;
        end else if (abort) begin
            // restart from outside drops whatever was being summed
            active <= 1'b0;
            step <= '0;
        end else if (req.go) begin
            active <= 1'b1;
            step <= '0;
        end else if (active) begin
            if (final_step) begin
                active <= 1'b0;
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // operands, tags and accumulator follow the control state above
    always_ff @(posedge vector_mult_done) begin
        if (req.go) begin
            a_q <= req.a_vec;
            b_q <= req.b_vec;
            row_q <= req.row;
            col_q <= req.col;
            last_q <= req.last;
            acc <= '0;
        end else if (active) begin
            acc <= acc + lane_sum;
        end
    end

endmodule

//--- verilog.f
src/mat_dims_pkg.sv
src/mat_data_pkg.sv
src/vec_dot_seq.sv
src/mat_mult_seq.sv
src/mat_result_store.sv
src/mat_mult_top.sv
dv/mat_mult_checks.sv
dv/mat_mult_tb.sv
